// File: common/if_settings.svh
// data and parcel widths, reset pc, parcel queue depth and fetch stop threshold
`ifndef IF_SETTINGS_SVH
`define IF_SETTINGS_SVH

// datapath
`define IF_XLEN            32
`define IF_PARCEL_W        16

// first fetch address out of reset
`define IF_PC_INIT         32'h200

//////////////////////////////
// parcel queue sizing
//////////////////////////////

`define IF_QUEUE_DEPTH     12
// requests stop here, which leaves room for three words in flight
`define IF_FULL_THRESHOLD  6

`endif

// File: common/if_pkg.sv
// fetch stage vector typedefs and the structs passed between its blocks
`default_nettype none

`include "if_settings.svh"

package if_pkg;

  typedef logic [`IF_XLEN-1:0]     xlen_t;    // address or data word
  typedef logic [`IF_PARCEL_W-1:0] parcel_t;  // half word of instruction stream
  typedef logic [`IF_XLEN-1:0]     insn_t;    // rv32 encoding

  // one beat returned by the instruction memory
  typedef struct packed {
    xlen_t data;
    logic  valid;
    logic  error;   // bus error on this word
  } imem_rsp_t;

  //////////////////////////////
  // queue head as seen by the decode side
  //////////////////////////////

  typedef struct packed {
    parcel_t lo;
    parcel_t hi;
    logic    valid;       // enough parcels for the decoded length
    logic    compressed;
    logic    error;       // any parcel used carries a bus error
  } parcel_window_t;

  typedef struct packed {
    insn_t insn;
    logic  illegal;
  } expand_t;

  // registered stage output
  typedef struct packed {
    xlen_t pc;
    insn_t insn;
    logic  bubble;
    logic  illegal;
    logic  access_fault;
  } if_out_t;

endpackage

`default_nettype wire

// File: fetch/fetch_req.sv
// instruction memory address register and fetch request generation
`timescale 1ns/1ns
`default_nettype none

`include "if_settings.svh"

module fetch_req
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  input  wire logic          almost_full_i,  // parcel queue near its limit
  input  wire logic          flush_i,
  input  wire if_pkg::xlen_t flush_pc_i,

  output      logic          imem_req_o,
  input  wire logic          imem_ack_i,
  output      if_pkg::xlen_t imem_adr_o
);

  if_pkg::xlen_t adr_q;
  logic          accept;

  // fetch runs ahead linearly, stops on full queue or flush
  assign imem_req_o = ~almost_full_i & ~flush_i;
  assign accept     = imem_req_o & imem_ack_i;

  //////////////////////////////
  // address register
  //////////////////////////////

  // a branch may land on a half word, the fetch itself is always a word
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      adr_q <= `IF_PC_INIT;
    else if (flush_i)
      adr_q <= {flush_pc_i[`IF_XLEN-1:2], 2'b00};
    else if (accept)
      adr_q <= {adr_q[`IF_XLEN-1:2] + 1'b1, 2'b00};  // next word
  end

  assign imem_adr_o = adr_q;

endmodule

`default_nettype wire

// File: fetch/parcel_queue.sv
// parcel shift queue with error flags, instruction length decode and pop control
`timescale 1ns/1ns
`default_nettype none

`include "if_settings.svh"

module parcel_queue
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,

  input  wire logic                   flush_i,
  input  wire if_pkg::xlen_t          flush_pc_i,

  input  wire if_pkg::imem_rsp_t      rsp_i,
  input  wire logic                   pop_en_i,

  output      if_pkg::parcel_window_t window_o,
  output      logic                   almost_full_o
);

  localparam int CNT_W = $clog2(`IF_QUEUE_DEPTH + 1);

  if_pkg::parcel_t [`IF_QUEUE_DEPTH-1:0] q_q, q_nxt;
  logic [`IF_QUEUE_DEPTH-1:0]            err_q, err_nxt;
  logic [CNT_W-1:0]                      cnt_q, cnt_nxt;
  logic                                  skip_q;  // drop low half of next beat

  logic             compressed;
  logic             head_valid;
  logic [1:0]       pop_n;
  logic             push_lo, push_hi;
  logic [CNT_W-1:0] wr_lo, wr_hi;

  //////////////////////////////
  // head decode
  //////////////////////////////

  assign compressed = ~&q_q[0][1:0];
  assign head_valid = compressed ? (cnt_q != '0) : (cnt_q >= CNT_W'(2));

  assign pop_n = (head_valid & pop_en_i) ? (compressed ? 2'd1 : 2'd2) : 2'd0;

  // beats landing in the flush cycle belong to the old stream
  assign push_lo = rsp_i.valid & ~flush_i & ~skip_q;
  assign push_hi = rsp_i.valid & ~flush_i;

  assign wr_lo = cnt_q - CNT_W'(pop_n);
  assign wr_hi = push_lo ? wr_lo + 1'b1 : wr_lo;

  assign cnt_nxt = wr_lo + CNT_W'(push_lo) + CNT_W'(push_hi);

  always_comb
  begin
    q_nxt   = q_q >> (`IF_PARCEL_W * pop_n);
    err_nxt = err_q >> pop_n;
    for (int i = 0; i < `IF_QUEUE_DEPTH; i++)
    begin
      if (push_lo && i == int'(wr_lo))
      begin
        q_nxt[i]   = rsp_i.data[`IF_PARCEL_W-1:0];
        err_nxt[i] = rsp_i.error;
      end
      if (push_hi && i == int'(wr_hi))
      begin
        q_nxt[i]   = rsp_i.data[`IF_XLEN-1:`IF_PARCEL_W];
        err_nxt[i] = rsp_i.error;
      end
    end
  end

  // parcel storage
  always_ff @(posedge clk_i)
  begin
    q_q   <= q_nxt;
    err_q <= err_nxt;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cnt_q  <= '0;
      skip_q <= 1'b0;
    end
    else if (flush_i)
    begin
      cnt_q  <= '0;
      skip_q <= flush_pc_i[1];  // target in upper half of its word
    end
    else
    begin
      cnt_q <= cnt_nxt;
      if (rsp_i.valid)
        skip_q <= 1'b0;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign window_o.lo         = q_q[0];
  assign window_o.hi         = q_q[1];
  assign window_o.valid      = head_valid;
  assign window_o.compressed = compressed;
  assign window_o.error      = err_q[0] | (~compressed & err_q[1]);

  assign almost_full_o = cnt_q >= CNT_W'(`IF_FULL_THRESHOLD);

endmodule

`default_nettype wire

// File: rvc/rvc_expander.sv
// rvc to rv32 expansion of the queue head and illegal encoding detection
`timescale 1ns/1ns
`default_nettype none

module rvc_expander
(
  input  wire if_pkg::parcel_window_t window_i,
  output      if_pkg::expand_t        expand_o
);

  // rv32 major opcodes
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam if_pkg::insn_t EBREAK = 32'h0010_0073;

  if_pkg::parcel_t p;
  logic [4:0]      rd, rs2;     // full register fields
  logic [4:0]      rs1p, rs2p;  // compact fields, x8..x15
  logic [11:0]     ci_imm;
  logic [11:0]     cl_imm;      // c.lw / c.sw word offset
  logic [11:0]     cj_off;
  logic [12:0]     cb_imm;

  assign p    = window_i.lo;
  assign rd   = p[11:7];
  assign rs2  = p[6:2];
  assign rs1p = {2'b01, p[9:7]};
  assign rs2p = {2'b01, p[4:2]};

  //////////////////////////////
  // immediates
  //////////////////////////////

  assign ci_imm = {{6{p[12]}}, p[12], p[6:2]};
  assign cl_imm = {5'b00000, p[5], p[12:10], p[6], 2'b00};
  assign cj_off = {p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
  assign cb_imm = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};

  always_comb
  begin
    expand_o.insn    = {16'h0000, p};  // reserved forms leave the parcel as is
    expand_o.illegal = 1'b0;
    if (!window_i.compressed)
      expand_o.insn = {window_i.hi, window_i.lo};
    else
    begin
      case ({p[15:13], p[1:0]})
        5'b010_00: expand_o.insn = {cl_imm, rs1p, 3'b010, rs2p, OP_LOAD};  // c.lw
        5'b110_00: expand_o.insn = {cl_imm[11:5], rs2p, rs1p, 3'b010, cl_imm[4:0], OP_STORE};
        5'b000_01: expand_o.insn = {ci_imm, rd, 3'b000, rd, OP_IMM};       // c.addi, c.nop
        5'b010_01: expand_o.insn = {ci_imm, 5'd0, 3'b000, rd, OP_IMM};     // c.li
        5'b101_01: expand_o.insn = {cj_off[11], cj_off[10:1], cj_off[11],
                                    {8{cj_off[11]}}, 5'd0, OP_JAL};       // c.j
        5'b110_01,
        5'b111_01: expand_o.insn = {cb_imm[12], cb_imm[10:5], 5'd0, rs1p, 2'b00, p[13],
                                    cb_imm[4:1], cb_imm[11], OP_BRANCH};  // c.beqz, c.bnez
        5'b100_01:
        begin
          // only the register-register group, no w forms on rv32
          if (p[12:10] == 3'b011)
          begin
            case (p[6:5])
              2'b00:   expand_o.insn = {7'b0100000, rs2p, rs1p, 3'b000, rs1p, OP_REG};
              2'b01:   expand_o.insn = {7'b0000000, rs2p, rs1p, 3'b100, rs1p, OP_REG};
              2'b10:   expand_o.insn = {7'b0000000, rs2p, rs1p, 3'b110, rs1p, OP_REG};
              default: expand_o.insn = {7'b0000000, rs2p, rs1p, 3'b111, rs1p, OP_REG};
            endcase
          end
          else
            expand_o.illegal = 1'b1;
        end
        5'b100_10:
        begin
          if (rs2 != 5'd0)  // c.mv / c.add
            expand_o.insn = {7'b0000000, rs2, (p[12] ? rd : 5'd0), 3'b000, rd, OP_REG};
          else if (rd != 5'd0)  // c.jr / c.jalr
            expand_o.insn = {12'h000, rd, 3'b000, 4'b0000, p[12], OP_JALR};
          else if (p[12])
            expand_o.insn = EBREAK;
          else
            expand_o.illegal = 1'b1;  // c.jr with x0
        end
        default: expand_o.illegal = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/pc_tracker.sv
// next program counter with flush load and 2 or 4 byte advance
`timescale 1ns/1ns
`default_nettype none

`include "if_settings.svh"

module pc_tracker
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,

  input  wire logic                   flush_i,
  input  wire if_pkg::xlen_t          flush_pc_i,  // branch target

  input  wire if_pkg::parcel_window_t window_i,
  input  wire logic                   pop_en_i,

  output      if_pkg::xlen_t          nxt_pc_o
);

  if_pkg::xlen_t nxt_pc_q;
  logic          consume;

  assign consume = pop_en_i & window_i.valid;

  //////////////////////////////
  // pc register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      nxt_pc_q <= `IF_PC_INIT;
    else if (flush_i)
      nxt_pc_q <= flush_pc_i;  // keeps bit 1 of the target
    else if (consume)
      nxt_pc_q <= nxt_pc_q + (window_i.compressed ? 32'd2 : 32'd4);
  end

  assign nxt_pc_o = nxt_pc_q;

endmodule

`default_nettype wire

// File: design/if_stage_reg.sv
// fetch stage output register with bubble and exception flags
`timescale 1ns/1ns
`default_nettype none

`include "if_settings.svh"

module if_stage_reg
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,

  input  wire logic                   flush_i,
  input  wire logic                   pd_stall_i,  // decode not ready

  input  wire if_pkg::parcel_window_t window_i,
  input  wire if_pkg::expand_t        expand_i,
  input  wire if_pkg::xlen_t          pc_i,

  output      if_pkg::if_out_t        if_o
);

  if_pkg::if_out_t out_q;
  if_pkg::if_out_t out_nxt;
  logic            consume;

  assign consume = window_i.valid & ~flush_i;

  // a bubble carries no instruction and no exception
  always_comb
  begin
    out_nxt.pc           = pc_i;
    out_nxt.insn         = consume ? expand_i.insn : '0;
    out_nxt.bubble       = ~consume;
    out_nxt.illegal      = consume & expand_i.illegal;
    out_nxt.access_fault = consume & window_i.error;
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      out_q              <= '0;
      out_q.pc           <= `IF_PC_INIT;
      out_q.bubble       <= 1'b1;
    end
    else if (!pd_stall_i)
      out_q <= out_nxt;  // holds while decode stalls
  end

  assign if_o = out_q;

endmodule

`default_nettype wire

// File: design/if_top.sv
// fetch stage top level connecting request, queue, expander, pc and output register
`timescale 1ns/1ns
`default_nettype none

module if_top
(
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  // instruction memory
  output      logic              imem_req_o,
  input  wire logic              imem_ack_i,
  output      if_pkg::xlen_t     imem_adr_o,
  output      logic              imem_flush_o,
  input  wire if_pkg::imem_rsp_t imem_rsp_i,

  // pipeline side
  input  wire logic              pd_stall_i,
  input  wire logic              bu_flush_i,
  input  wire if_pkg::xlen_t     bu_nxt_pc_i,
  output      if_pkg::if_out_t   if_o
);

  logic                   almost_full;
  logic                   pop_en;
  if_pkg::parcel_window_t window;
  if_pkg::expand_t        expand;
  if_pkg::xlen_t          nxt_pc;

  assign pop_en       = ~pd_stall_i;
  assign imem_flush_o = bu_flush_i;  // memory drops unreturned words

  //////////////////////////////
  // fetch side
  //////////////////////////////

  fetch_req u_fetch_req (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .almost_full_i ( almost_full ),
    .flush_i       ( bu_flush_i  ),
    .flush_pc_i    ( bu_nxt_pc_i ),
    .imem_req_o    ( imem_req_o  ),
    .imem_ack_i    ( imem_ack_i  ),
    .imem_adr_o    ( imem_adr_o  )
  );

  parcel_queue u_parcel_queue (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .flush_i       ( bu_flush_i  ),
    .flush_pc_i    ( bu_nxt_pc_i ),
    .rsp_i         ( imem_rsp_i  ),
    .pop_en_i      ( pop_en      ),
    .window_o      ( window      ),
    .almost_full_o ( almost_full )
  );

  //////////////////////////////
  // decode side
  //////////////////////////////

  rvc_expander u_rvc_expander (
    .window_i ( window ),
    .expand_o ( expand )
  );

  pc_tracker u_pc_tracker (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .flush_i    ( bu_flush_i  ),
    .flush_pc_i ( bu_nxt_pc_i ),
    .window_i   ( window      ),
    .pop_en_i   ( pop_en      ),
    .nxt_pc_o   ( nxt_pc      )
  );

  if_stage_reg u_if_stage_reg (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .flush_i    ( bu_flush_i ),
    .pd_stall_i ( pd_stall_i ),
    .window_i   ( window     ),
    .expand_i   ( expand     ),
    .pc_i       ( nxt_pc     ),
    .if_o       ( if_o       )
  );

endmodule

`default_nettype wire

// File: tests/if_checker.sv
// concurrent assertions bound to if_top on the fetch handshake and the stage output
`timescale 1ns/1ns
`default_nettype none

module if_checker
(
  input wire logic            clk_i,
  input wire logic            rst_ni,
  input wire logic            imem_req_o,
  input wire logic            imem_ack_i,
  input wire if_pkg::xlen_t   imem_adr_o,
  input wire logic            imem_flush_o,
  input wire logic            pd_stall_i,
  input wire if_pkg::if_out_t if_o
);

  int fail_cnt = 0;  // count of failed assertions

  //////////////////////////////
  // memory side
  //////////////////////////////

  // pending request keeps its address
  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_o && !imem_ack_i && !imem_flush_o |=> $stable(imem_adr_o))
    else begin $error("fetch address moved while pending"); fail_cnt++; end

  no_req_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_flush_o |-> !imem_req_o)
    else begin $error("request raised during flush"); fail_cnt++; end

  //////////////////////////////
  // output side
  //////////////////////////////

  hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_stall_i |=> $stable(if_o))
    else begin $error("output changed under stall"); fail_cnt++; end

  bubble_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rst_ni) |-> if_o.bubble)
    else begin $error("no bubble after reset"); fail_cnt++; end

endmodule

bind if_top if_checker u_if_checker (.*);

`default_nettype wire

// File: tests/if_tb.sv
// fetch stage testbench with memory model, reference rvc expansion and output checks
`timescale 1ns/1ns
`default_nettype none

`include "if_settings.svh"

module if_tb;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   imem_req_o;
  logic                   imem_ack_i;
  if_pkg::xlen_t          imem_adr_o;
  logic                   imem_flush_o;
  if_pkg::imem_rsp_t      imem_rsp_i;
  logic                   pd_stall_i;
  logic                   bu_flush_i;
  if_pkg::xlen_t          bu_nxt_pc_i;
  if_pkg::if_out_t        if_o;

  if_pkg::xlen_t prog [0:13];       // program words from the reset pc
  if_pkg::xlen_t pend_adr [$];      // accepted but not yet returned
  int            pend_due [$];
  int            cyc = 0;
  int            last_due = 0;
  if_pkg::xlen_t exp_pc = `IF_PC_INIT;
  logic          prev_stall = 1'b0;
  logic          fl_req = 1'b0;
  if_pkg::xlen_t fl_target;

  always #2 clk_i = ~clk_i;

  if_top DUT (.*);

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  //////////////////////////////
  // memory contents
  //////////////////////////////

  function automatic if_pkg::xlen_t mem_word(input if_pkg::xlen_t adr);
    if (adr >= 32'h200 && adr < 32'h238)
      return prog[(adr - 32'h200) >> 2];
    return ((adr * 32'h9e37) ^ 32'h1234_5670) | 32'h3;  // 32-bit filler
  endfunction

  function automatic logic [15:0] parcel_at(input if_pkg::xlen_t pc);
    if_pkg::xlen_t w;
    w = mem_word({pc[31:2], 2'b00});
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  // rvc to rv32 with the illegal flag in bit 32
  function automatic logic [32:0] ref_expand(input logic [15:0] p);
    logic [31:0] ins;
    logic        il;
    logic [4:0]  r1c, r2c, rd, rs2;
    logic [11:0] im;
    logic [20:0] jo;
    logic [12:0] bo;
    ins = {16'h0000, p};
    il  = 1'b0;
    r1c = {2'b01, p[9:7]};
    r2c = {2'b01, p[4:2]};
    rd  = p[11:7];
    rs2 = p[6:2];
    case ({p[15:13], p[1:0]})
      5'b010_00:
      begin
        im  = {5'd0, p[5], p[12:10], p[6], 2'b00};
        ins = {im, r1c, 3'b010, r2c, 7'h03};
      end
      5'b110_00:
      begin
        im  = {5'd0, p[5], p[12:10], p[6], 2'b00};
        ins = {im[11:5], r2c, r1c, 3'b010, im[4:0], 7'h23};
      end
      5'b000_01:
      begin
        im  = {{7{p[12]}}, p[6:2]};
        ins = {im, rd, 3'b000, rd, 7'h13};
      end
      5'b010_01:
      begin
        im  = {{7{p[12]}}, p[6:2]};
        ins = {im, 5'd0, 3'b000, rd, 7'h13};
      end
      5'b101_01:
      begin
        jo  = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
        ins = {jo[20], jo[10:1], jo[11], jo[19:12], 5'd0, 7'h6f};
      end
      5'b110_01, 5'b111_01:
      begin
        bo  = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
        ins = {bo[12], bo[10:5], 5'd0, r1c, 2'b00, p[13], bo[4:1], bo[11], 7'h63};
      end
      5'b100_01:
      begin
        if (p[12:10] != 3'b011)
          il = 1'b1;
        else if (p[6:5] == 2'b00)
          ins = {7'h20, r2c, r1c, 3'b000, r1c, 7'h33};  // sub
        else
          ins = {7'h00, r2c, r1c, (p[6:5] == 2'b01) ? 3'b100 :
                 (p[6:5] == 2'b10) ? 3'b110 : 3'b111, r1c, 7'h33};
      end
      5'b100_10:
      begin
        if (rs2 != 5'd0)
          ins = {7'h00, rs2, p[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
        else if (rd != 5'd0)
          ins = {12'h000, rd, 3'b000, 4'b0000, p[12], 7'h67};
        else if (p[12])
          ins = 32'h0010_0073;  // ebreak
        else
          il = 1'b1;
      end
      default: il = 1'b1;
    endcase
    return {il, ins};
  endfunction

  //////////////////////////////
  // memory model and drivers
  //////////////////////////////

  always @(negedge clk_i)
  begin
    int lat;
    if (rst_ni && imem_flush_o)
    begin
      pend_adr.delete();
      pend_due.delete();
      last_due = cyc;
    end
    else if (rst_ni && imem_req_o && imem_ack_i)
    begin
      lat      = 1 + int'($urandom % 3);
      last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
      pend_adr.push_back(imem_adr_o);
      pend_due.push_back(last_due);
    end
  end

  always @(posedge clk_i)
  begin
    #1;
    cyc++;
    imem_rsp_i = '0;
    if (pend_adr.size() > 0 && pend_due[0] <= cyc)
    begin
      imem_rsp_i.valid = 1'b1;
      imem_rsp_i.data  = mem_word(pend_adr[0]);
      imem_rsp_i.error = pend_adr[0] == 32'h22c;  // faulty word
      void'(pend_adr.pop_front());
      void'(pend_due.pop_front());
    end
    imem_ack_i = ($urandom % 4) != 0;
    pd_stall_i = ($urandom % 5) == 0;
    bu_flush_i = fl_req;
    if (fl_req)
    begin
      bu_nxt_pc_i = fl_target;
      pd_stall_i  = 1'b0;
      fl_req      = 1'b0;
    end
  end

  //////////////////////////////
  // output checks
  //////////////////////////////

  always @(negedge clk_i)
  begin
    logic [15:0] lo;
    logic [32:0] rx;
    logic        comp;
    logic        fault;
    if (rst_ni)
    begin
      if (DUT.u_if_checker.fail_cnt != 0)
        report_failure("a bound assertion on the DUT failed");
      if (!prev_stall && !if_o.bubble)
      begin
        lo    = parcel_at(exp_pc);
        comp  = lo[1:0] != 2'b11;
        rx    = comp ? ref_expand(lo) : {1'b0, parcel_at(exp_pc + 2), lo};
        fault = (exp_pc[31:2] == 30'h8b) || (!comp && ((exp_pc + 2) >> 2) == 32'h8b);
        assert (if_o.pc == exp_pc) else report_mismatch("if_o.pc", if_o.pc, exp_pc);
        assert (if_o.insn == rx[31:0]) else report_mismatch("if_o.insn", if_o.insn, rx[31:0]);
        assert (if_o.illegal == rx[32])
          else report_mismatch("if_o.illegal", if_o.illegal, rx[32]);
        assert (if_o.access_fault == fault)
          else report_mismatch("if_o.access_fault", if_o.access_fault, fault);
        exp_pc = exp_pc + (comp ? 32'd2 : 32'd4);
      end
      if (bu_flush_i)
        exp_pc = bu_nxt_pc_i;  // old stream ends here
      prev_stall = pd_stall_i;
    end
  end

  task automatic wait_pc(input if_pkg::xlen_t target);
    int n;
    n = 0;
    while (exp_pc < target)
    begin
      @(posedge clk_i);
      n++;
      if (n > 2000)
        report_failure("pc did not reach the target in time");
    end
  endtask

  task automatic branch_to(input if_pkg::xlen_t target);
    @(posedge clk_i);
    fl_target = target;
    fl_req    = 1'b1;
    repeat (2) @(posedge clk_i);
  endtask

  initial
  begin
    void'($urandom(32'h57b9));
    prog[0]  = 32'h0010_0093;
    prog[1]  = 32'h0020_8113;
    prog[2]  = 32'h12fd_428d;  // c.li c.addi
    prog[3]  = 32'hc504_4144;  // c.lw c.sw
    prog[4]  = 32'h8c25_8c05;
    prog[5]  = 32'h8c65_8c45;
    prog[6]  = 32'h931e_831e;  // mv add
    prog[7]  = 32'h9082_8082;  // jr jalr
    prog[8]  = 32'hb6d5_9002;
    prog[9]  = 32'hf3fd_c4e1;
    prog[10] = 32'h0506_0000;  // illegal pair
    prog[11] = 32'h0030_0193;  // faulty word
    prog[12] = 32'h0213_0001;  // 32-bit across words
    prog[13] = 32'h0305_0040;
    rst_ni      = 1'b0;
    imem_ack_i  = 1'b0;
    imem_rsp_i  = '0;
    pd_stall_i  = 1'b0;
    bu_flush_i  = 1'b0;
    bu_nxt_pc_i = '0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    assert (if_o.bubble == 1'b1) else report_mismatch("if_o.bubble", if_o.bubble, 1'b1);
    assert (if_o.pc == 32'h200) else report_mismatch("if_o.pc", if_o.pc, 32'h200);
    assert (imem_req_o == 1'b1) else report_mismatch("imem_req_o", imem_req_o, 1'b1);
    assert (imem_adr_o == 32'h200) else report_mismatch("imem_adr_o", imem_adr_o, 32'h200);
    wait_pc(32'h250);
    branch_to(32'h20c);
    wait_pc(32'h240);
    branch_to(32'h232);
    wait_pc(32'h248);
    if (DUT.u_if_checker.fail_cnt != 0)
    begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/if_pkg.sv
fetch/fetch_req.sv
fetch/parcel_queue.sv
rvc/rvc_expander.sv
design/pc_tracker.sv
design/if_stage_reg.sv
design/if_top.sv
tests/if_checker.sv
tests/if_tb.sv

// File: Bender.yml
package:
  name: if_stage

sources:
  - include_dirs:
      - common
    files:
      - common/if_pkg.sv
      - fetch/fetch_req.sv
      - fetch/parcel_queue.sv
      - rvc/rvc_expander.sv
      - design/pc_tracker.sv
      - design/if_stage_reg.sv
      - design/if_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/if_checker.sv
      - tests/if_tb.sv
